/* logic/raster_link_params.svh */
`ifndef RASTER_LINK_PARAMS_SVH
`define RASTER_LINK_PARAMS_SVH

// cycles ignored after cs_n falls
`define LINK_SETTLE_CYCLES 8

// nybbles per field
`define LINK_VERT_NYB  27
`define LINK_TRI_NYB   6
`define LINK_COUNT_NYB 2

// memory depths in elements
`define LINK_VERT_DEPTH 64
`define LINK_TRI_DEPTH  64

`define LINK_BAD_ID 8'hFF   // reply id of a refused buffer

`endif

/* logic/raster_link_pkg.sv */
`default_nettype none

package raster_link_pkg;

    typedef logic [3:0]   nybble_t;
    typedef logic [7:0]   elem_count_t;
    typedef logic [7:0]   buf_id_t;
    typedef logic [12:0]  vert_addr_t;
    typedef logic [12:0]  tri_addr_t;
    typedef logic [107:0] vert_word_t;  // 3 x 32b coords + 3 x 4b attributes
    typedef logic [23:0]  tri_word_t;   // 3 x 8b vertex indices

    typedef enum logic [3:0] {
        OP_CREATE_VERT = 4'd1,
        OP_CREATE_TRI  = 4'd2
    } opcode_t;

    typedef enum logic [3:0] {
        OK             = 4'd0,
        INVALID_OPCODE = 4'd1,
        OUT_OF_MEMORY  = 4'd2,
        INVALID_COUNT  = 4'd3
    } status_t;

    typedef enum logic [2:0] {
        SETTLE,
        LOAD_OP,
        LOAD_COUNT,
        LOAD_DATA,
        REPLY_ID_HI,
        REPLY_ID_LO,
        STATUS_OUT
    } link_state_t;

    typedef enum logic {
        KIND_VERT,
        KIND_TRI
    } buf_kind_t;

    typedef struct packed {
        buf_id_t     id;
        vert_addr_t  base;
        elem_count_t count;
    } vert_hdr_t;

    typedef struct packed {
        buf_id_t     id;
        tri_addr_t   base;
        elem_count_t count;
    } tri_hdr_t;

    typedef struct packed {
        vert_addr_t addr;
        vert_word_t word;
    } vert_write_t;

    typedef struct packed {
        tri_addr_t addr;
        tri_word_t word;
    } tri_write_t;

endpackage

`default_nettype wire

/* logic/frame_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_link_params.svh"

module frame_counter (
    input  logic                          sck,
    input  logic                          rst,
    input  logic                          cs_n,
    input  raster_link_pkg::link_state_t  state,
    input  raster_link_pkg::buf_kind_t    kind,
    input  raster_link_pkg::elem_count_t  elem_count,
    output logic                          settled,
    output logic                          field_done,
    output logic                          last_elem
);
    import raster_link_pkg::*;

    localparam int SETTLE_W = $clog2(`LINK_SETTLE_CYCLES);
    localparam int NYB_W    = $clog2(`LINK_VERT_NYB + 1);

    logic [SETTLE_W-1:0] settle_cnt;
    logic [NYB_W-1:0]    nyb_cnt;
    logic [NYB_W-1:0]    field_len;
    elem_count_t         elem_cnt;
    logic                loading;

    assign loading = (state == LOAD_COUNT) || (state == LOAD_DATA);

    always_comb begin
        if (state == LOAD_COUNT)
            field_len = NYB_W'(`LINK_COUNT_NYB);
        else if (kind == KIND_TRI)
            field_len = NYB_W'(`LINK_TRI_NYB);
        else
            field_len = NYB_W'(`LINK_VERT_NYB);
    end

    assign settled    = settle_cnt == SETTLE_W'(`LINK_SETTLE_CYCLES - 1);
    assign field_done = loading && !cs_n && (nyb_cnt == field_len - 1'b1);
    assign last_elem  = elem_cnt == elem_count - 1'b1;

    always_ff @(posedge sck) begin
        if (rst || cs_n || state != SETTLE) begin
            settle_cnt <= '0;
        end else begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // nybble position inside the current field
    always_ff @(posedge sck) begin
        if (rst || cs_n || !loading || field_done) begin
            nyb_cnt <= '0;
        end else begin
            nyb_cnt <= nyb_cnt + 1'b1;
        end
    end

    always_ff @(posedge sck) begin
        if (rst || state != LOAD_DATA) begin
            elem_cnt <= '0;
        end else if (field_done) begin
            elem_cnt <= elem_cnt + 1'b1;  // next element of the buffer
        end
    end

    nyb_in_range: assert property (@(posedge sck) disable iff (rst)
        loading |-> nyb_cnt < field_len);

endmodule

`default_nettype wire

/* logic/link_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module link_fsm (
    input  logic                          sck,
    input  logic                          rst,
    input  logic                          cs_n,
    input  raster_link_pkg::nybble_t      spi_in,
    input  logic                          settled,
    input  logic                          field_done,
    input  logic                          last_elem,
    input  logic                          hdr_ok,
    output raster_link_pkg::link_state_t  state,
    output raster_link_pkg::buf_kind_t    kind,
    output logic                          spi_oe
);
    import raster_link_pkg::*;

    link_state_t state_nx;
    opcode_t     op;

    assign op = opcode_t'(spi_in);

    always_comb begin
        state_nx = state;
        case (state)
            SETTLE: begin
                if (settled)
                    state_nx = LOAD_OP;
            end
            LOAD_OP: begin
                if (op == OP_CREATE_VERT || op == OP_CREATE_TRI)
                    state_nx = LOAD_COUNT;
                else
                    state_nx = STATUS_OUT;  // bad opcode gets status only
            end
            LOAD_COUNT: begin
                if (field_done)
                    state_nx = hdr_ok ? LOAD_DATA : REPLY_ID_HI;
            end
            LOAD_DATA: begin
                if (field_done && last_elem)
                    state_nx = REPLY_ID_HI;
            end
            REPLY_ID_HI: begin
                state_nx = REPLY_ID_LO;
            end
            REPLY_ID_LO: begin
                state_nx = STATUS_OUT;
            end
            STATUS_OUT: begin
                state_nx = LOAD_OP;  // back to back commands skip settle
            end
            default: begin
                state_nx = SETTLE;
            end
        endcase
        if (cs_n)
            state_nx = SETTLE;  // host let go of the bus mid frame
    end

    always_ff @(posedge sck) begin
        if (rst) begin
            state  <= SETTLE;
            kind   <= KIND_VERT;
            spi_oe <= 1'b0;
        end else begin
            state  <= state_nx;
            spi_oe <= state_nx inside {REPLY_ID_HI, REPLY_ID_LO, STATUS_OUT};
            if (state == LOAD_OP)
                kind <= (op == OP_CREATE_TRI) ? KIND_TRI : KIND_VERT;
        end
    end

    // reply drive never outlasts id hi, id lo and status
    oe_burst_len: assert property (@(posedge sck) disable iff (rst)
        spi_oe && $past(spi_oe) && $past(spi_oe, 2) |=> !spi_oe);

endmodule

`default_nettype wire

/* logic/nybble_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module nybble_shifter (
    input  logic                          sck,
    input  logic                          rst,
    input  raster_link_pkg::link_state_t  state,
    input  raster_link_pkg::nybble_t      spi_in,
    output raster_link_pkg::vert_word_t   field
);
    import raster_link_pkg::*;

    localparam int FIELD_W = $bits(vert_word_t);

    vert_word_t shift_q;

    // field already holds the nybble on the bus this cycle
    assign field = {shift_q[FIELD_W-5:0], spi_in};

    always_ff @(posedge sck) begin
        if (rst) begin
            shift_q <= '0;
        end else if (state == LOAD_COUNT || state == LOAD_DATA) begin
            shift_q <= field;  // msb first
        end
    end

endmodule

`default_nettype wire

/* logic/buffer_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_link_params.svh"

module buffer_allocator (
    input  logic                          sck,
    input  logic                          rst,
    input  raster_link_pkg::link_state_t  state,
    input  raster_link_pkg::buf_kind_t    kind,
    input  raster_link_pkg::vert_word_t   field,
    input  logic                          field_done,
    input  logic                          last_elem,
    output logic                          hdr_ok,
    output raster_link_pkg::elem_count_t  elem_count,
    output logic                          vert_hdr_valid,
    output raster_link_pkg::vert_hdr_t    vert_hdr,
    output logic                          tri_hdr_valid,
    output raster_link_pkg::tri_hdr_t     tri_hdr,
    output logic                          vert_wr_valid,
    output raster_link_pkg::vert_write_t  vert_wr,
    output logic                          tri_wr_valid,
    output raster_link_pkg::tri_write_t   tri_wr,
    output raster_link_pkg::nybble_t      spi_out
);
    import raster_link_pkg::*;

    buf_id_t     next_vert_id, next_tri_id, reply_id;
    vert_addr_t  next_vert_base, vert_end;
    tri_addr_t   next_tri_base, tri_end;
    vert_addr_t  wr_addr;  // shared by both kinds, same width
    status_t     reply_status;
    elem_count_t cnt;
    logic        is_vert, cnt_zero, no_room;
    logic        take_count, take_elem, accept;

    assign is_vert  = kind == KIND_VERT;
    assign cnt      = field[7:0];
    assign vert_end = next_vert_base + vert_addr_t'(cnt);
    assign tri_end  = next_tri_base + tri_addr_t'(cnt);
    assign cnt_zero = cnt == '0;
    assign no_room  = is_vert ? (vert_end > `LINK_VERT_DEPTH) : (tri_end > `LINK_TRI_DEPTH);
    assign hdr_ok   = !cnt_zero && !no_room;

    assign take_count = (state == LOAD_COUNT) && field_done;
    assign take_elem  = (state == LOAD_DATA) && field_done;
    assign accept     = take_count && hdr_ok;

    always_ff @(posedge sck) begin
        if (rst) begin
            vert_hdr_valid <= 1'b0;
            tri_hdr_valid  <= 1'b0;
            vert_wr_valid  <= 1'b0;
            tri_wr_valid   <= 1'b0;
            next_vert_id   <= '0;
            next_tri_id    <= '0;
            next_vert_base <= '0;
            next_tri_base  <= '0;
            reply_status   <= OK;
        end else begin
            vert_hdr_valid <= accept && is_vert;
            tri_hdr_valid  <= accept && !is_vert;
            vert_wr_valid  <= take_elem && is_vert;
            tri_wr_valid   <= take_elem && !is_vert;
            if (accept && is_vert) begin
                next_vert_id   <= next_vert_id + 1'b1;
                next_vert_base <= vert_end;
            end
            if (accept && !is_vert) begin
                next_tri_id   <= next_tri_id + 1'b1;
                next_tri_base <= tri_end;
            end
            // a valid opcode always passes LOAD_COUNT, which overwrites this
            if (state == LOAD_OP)
                reply_status <= INVALID_OPCODE;
            else if (take_count && cnt_zero)
                reply_status <= INVALID_COUNT;
            else if (take_count && no_room)
                reply_status <= OUT_OF_MEMORY;
            else if (take_count)
                reply_status <= OK;
        end
    end

    always_ff @(posedge sck) begin
        if (take_count) begin
            elem_count <= cnt;
            wr_addr    <= is_vert ? next_vert_base : next_tri_base;
            vert_hdr   <= '{id: next_vert_id, base: next_vert_base, count: cnt};
            tri_hdr    <= '{id: next_tri_id, base: next_tri_base, count: cnt};
            if (!hdr_ok)
                reply_id <= `LINK_BAD_ID;
            else
                reply_id <= is_vert ? next_vert_id : next_tri_id;
        end
        if (take_elem) begin
            vert_wr <= '{addr: wr_addr, word: field};
            tri_wr  <= '{addr: tri_addr_t'(wr_addr), word: field[23:0]};
            if (!last_elem)
                wr_addr <= wr_addr + 1'b1;
        end
    end

    always_comb begin
        case (state)
            REPLY_ID_HI: spi_out = reply_id[7:4];
            REPLY_ID_LO: spi_out = reply_id[3:0];
            STATUS_OUT:  spi_out = nybble_t'(reply_status);
            default:     spi_out = '0;
        endcase
    end

    base_in_depth: assert property (@(posedge sck) disable iff (rst)
        next_vert_base <= `LINK_VERT_DEPTH && next_tri_base <= `LINK_TRI_DEPTH);

endmodule

`default_nettype wire

/* logic/raster_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_link_top (
    input  logic                          sck,
    input  logic                          rst,
    input  logic                          cs_n,
    input  raster_link_pkg::nybble_t      spi_in,
    output raster_link_pkg::nybble_t      spi_out,
    output logic                          spi_oe,
    output logic                          vert_hdr_valid,
    output raster_link_pkg::vert_hdr_t    vert_hdr,
    output logic                          tri_hdr_valid,
    output raster_link_pkg::tri_hdr_t     tri_hdr,
    output logic                          vert_wr_valid,
    output raster_link_pkg::vert_write_t  vert_wr,
    output logic                          tri_wr_valid,
    output raster_link_pkg::tri_write_t   tri_wr
);
    import raster_link_pkg::*;

    link_state_t state;
    buf_kind_t   kind;
    vert_word_t  field;
    elem_count_t elem_count;
    logic        settled, field_done, last_elem, hdr_ok;

    frame_counter frame_counter_i (
        .sck(sck), .rst(rst), .cs_n(cs_n), .state(state), .kind(kind),
        .elem_count(elem_count), .settled(settled), .field_done(field_done),
        .last_elem(last_elem)
    );

    link_fsm link_fsm_i (
        .sck(sck), .rst(rst), .cs_n(cs_n), .spi_in(spi_in), .settled(settled),
        .field_done(field_done), .last_elem(last_elem), .hdr_ok(hdr_ok),
        .state(state), .kind(kind), .spi_oe(spi_oe)
    );

    nybble_shifter nybble_shifter_i (
        .sck(sck), .rst(rst), .state(state), .spi_in(spi_in), .field(field)
    );

    buffer_allocator buffer_allocator_i (
        .sck(sck), .rst(rst), .state(state), .kind(kind), .field(field),
        .field_done(field_done), .last_elem(last_elem), .hdr_ok(hdr_ok),
        .elem_count(elem_count), .vert_hdr_valid(vert_hdr_valid), .vert_hdr(vert_hdr),
        .tri_hdr_valid(tri_hdr_valid), .tri_hdr(tri_hdr), .vert_wr_valid(vert_wr_valid),
        .vert_wr(vert_wr), .tri_wr_valid(tri_wr_valid), .tri_wr(tri_wr), .spi_out(spi_out)
    );

endmodule

`default_nettype wire

/* dv/link_vectors.svh */
`ifndef LINK_VECTORS_SVH
`define LINK_VECTORS_SVH

// columns: opcode, count, random words, data nybble where cs_n rises (-1 none),
// expected reply id, expected status
typedef struct packed {
    nybble_t     opcode;
    elem_count_t count;
    logic        rnd;      // else a counting pattern per element
    int          cut_nyb;
    buf_id_t     exp_id;
    status_t     exp_status;
} vec_row_t;

localparam int NUM_VECS = 11;

localparam vec_row_t LINK_VECTORS [NUM_VECS] = '{
    '{4'h1, 8'd3,  1'b1, -1, 8'h00, OK},
    '{4'h2, 8'd5,  1'b1, -1, 8'h00, OK},
    '{4'h2, 8'd4,  1'b0, -1, 8'h01, OK},              // tri base 5
    '{4'h1, 8'd62, 1'b1, -1, 8'hFF, OUT_OF_MEMORY},   // 3 + 62 passes depth 64
    '{4'h1, 8'd0,  1'b1, -1, 8'hFF, INVALID_COUNT},
    '{4'hF, 8'd0,  1'b0, -1, 8'h00, INVALID_OPCODE},
    '{4'h1, 8'd2,  1'b1, -1, 8'h01, OK},              // still base 3
    '{4'h1, 8'd2,  1'b1, 40, 8'h02, OK},              // cut inside element 1
    '{4'h1, 8'd1,  1'b0, -1, 8'h03, OK},
    '{4'h1, 8'd56, 1'b1, -1, 8'h04, OK},              // fills vertex memory exactly
    '{4'h1, 8'd1,  1'b1, -1, 8'hFF, OUT_OF_MEMORY}
};

`endif

/* dv/raster_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_link_params.svh"

module raster_link_tb;
    import raster_link_pkg::*;

    `include "link_vectors.svh"

    localparam int REPLY_TIMEOUT = 16;

    logic        sck, rst, cs_n, spi_oe;
    nybble_t     spi_in, spi_out, bus;
    logic        vert_hdr_valid, tri_hdr_valid, vert_wr_valid, tri_wr_valid;
    vert_hdr_t   vert_hdr;
    tri_hdr_t    tri_hdr;
    vert_write_t vert_wr;
    tri_write_t  tri_wr;

    vert_hdr_t   vert_hdr_q[$];
    tri_hdr_t    tri_hdr_q[$];
    vert_write_t vert_wr_q[$];
    tri_write_t  tri_wr_q[$];

    int   seed;
    int   vert_id, tri_id, vert_base, tri_base;  // allocation model
    logic reply_expected, frame_open;

    raster_link_top dut_i (
        .sck(sck), .rst(rst), .cs_n(cs_n), .spi_in(spi_in), .spi_out(spi_out),
        .spi_oe(spi_oe), .vert_hdr_valid(vert_hdr_valid), .vert_hdr(vert_hdr),
        .tri_hdr_valid(tri_hdr_valid), .tri_hdr(tri_hdr), .vert_wr_valid(vert_wr_valid),
        .vert_wr(vert_wr), .tri_wr_valid(tri_wr_valid), .tri_wr(tri_wr)
    );

    assign bus = spi_oe ? spi_out : spi_in;  // resolved quad-SPI data lines

    initial begin
        sck = 1'b0;
        forever #20 sck = ~sck;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_vert_hdr(input vert_hdr_t got, input vert_hdr_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: vert_hdr got %h expected %h", $time, got, exp));
    endtask

    task automatic check_tri_hdr(input tri_hdr_t got, input tri_hdr_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: tri_hdr got %h expected %h", $time, got, exp));
    endtask

    task automatic check_vert_wr(input vert_write_t got, input vert_write_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: vert_wr got %h expected %h", $time, got, exp));
    endtask

    task automatic check_tri_wr(input tri_write_t got, input tri_write_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: tri_wr got %h expected %h", $time, got, exp));
    endtask

    task automatic check_nybble(input string name, input nybble_t got, input nybble_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    function automatic vert_word_t make_word(input logic rnd, input int elem, input logic is_vert);
        vert_word_t  w;
        logic [31:0] r;
        if (rnd) begin
            r = $random(seed);
            w = {$random(seed), $random(seed), $random(seed), r[11:0]};
        end else begin
            w = {27{nybble_t'(elem + 1)}};
        end
        if (!is_vert)
            w = {84'b0, w[23:0]};  // triangle words are 24 bits
        return w;
    endfunction

    task automatic drive_nybble(input nybble_t nyb);
        @(negedge sck);
        reply_expected = 1'b0;
        cs_n           = 1'b0;
        spi_in         = nyb;
    endtask

    task automatic start_frame();
        repeat (`LINK_SETTLE_CYCLES) drive_nybble(4'h0);
        frame_open = 1'b1;
    endtask

    task automatic end_frame();
        @(negedge sck);
        reply_expected = 1'b0;
        cs_n           = 1'b1;
        spi_in         = 4'h0;
        frame_open     = 1'b0;
        repeat (3) @(negedge sck);
    endtask

    task automatic collect_reply(input logic valid_op, input buf_id_t id, input status_t status);
        int waited;
        waited         = 0;
        reply_expected = 1'b1;
        @(negedge sck);
        while (!spi_oe && waited < REPLY_TIMEOUT) begin
            waited++;
            @(negedge sck);
        end
        if (!spi_oe)
            fail_run("timed out waiting for the DUT to drive its reply");
        if (valid_op) begin
            check_nybble("reply id hi", bus, id[7:4]);
            @(negedge sck);
            check_nybble("spi_oe", {3'b0, spi_oe}, 4'h1);
            check_nybble("reply id lo", bus, id[3:0]);
            @(negedge sck);
            check_nybble("spi_oe", {3'b0, spi_oe}, 4'h1);
        end
        check_nybble("reply status", bus, nybble_t'(status));
    endtask

    task automatic run_command(input vec_row_t row);
        logic       is_vert, valid_op, cut;
        status_t    status;
        int         base, depth, nyb, sent;
        vert_word_t word;
        is_vert  = row.opcode == 4'h1;
        valid_op = is_vert || row.opcode == 4'h2;
        cut      = 1'b0;
        sent     = 0;
        base     = is_vert ? vert_base : tri_base;
        depth    = is_vert ? `LINK_VERT_DEPTH : `LINK_TRI_DEPTH;
        nyb      = is_vert ? `LINK_VERT_NYB : `LINK_TRI_NYB;
        if (!valid_op)
            status = INVALID_OPCODE;
        else if (row.count == 8'd0)
            status = INVALID_COUNT;
        else if (base + int'(row.count) > depth)
            status = OUT_OF_MEMORY;
        else
            status = OK;
        if (status != row.exp_status)
            fail_run($sformatf("table row for opcode %h disagrees with the model", row.opcode));
        drive_nybble(row.opcode);
        if (valid_op) begin
            drive_nybble(row.count[7:4]);  // high nybble first
            drive_nybble(row.count[3:0]);
        end
        if (status == OK) begin
            if (is_vert) begin
                vert_hdr_q.push_back('{id: buf_id_t'(vert_id), base: vert_addr_t'(base),
                                       count: row.count});
                vert_id   = vert_id + 1;
                vert_base = vert_base + int'(row.count);
            end else begin
                tri_hdr_q.push_back('{id: buf_id_t'(tri_id), base: tri_addr_t'(base),
                                      count: row.count});
                tri_id   = tri_id + 1;
                tri_base = tri_base + int'(row.count);
            end
            for (int e = 0; e < int'(row.count) && !cut; e++) begin
                word = make_word(row.rnd, e, is_vert);
                for (int n = nyb - 1; n >= 0 && !cut; n--) begin
                    if (sent == row.cut_nyb)
                        cut = 1'b1;
                    else
                        drive_nybble(word[4*n +: 4]);
                    sent++;
                end
                if (!cut && is_vert)
                    vert_wr_q.push_back('{addr: vert_addr_t'(base + e), word: word});
                else if (!cut)
                    tri_wr_q.push_back('{addr: tri_addr_t'(base + e), word: word[23:0]});
            end
        end
        if (cut)
            end_frame();  // host lets go mid element
        else
            collect_reply(valid_op, row.exp_id, row.exp_status);
    endtask

    // record and bus monitors, sampled before the edge updates them
    always @(posedge sck) begin
        if (!rst && spi_oe && !reply_expected)
            fail_run("spi_oe went high outside a reply phase");
        if (!rst && vert_hdr_valid && vert_hdr_q.size() == 0)
            fail_run("unexpected vertex header record");
        else if (!rst && vert_hdr_valid)
            check_vert_hdr(vert_hdr, vert_hdr_q.pop_front());
        if (!rst && tri_hdr_valid && tri_hdr_q.size() == 0)
            fail_run("unexpected triangle header record");
        else if (!rst && tri_hdr_valid)
            check_tri_hdr(tri_hdr, tri_hdr_q.pop_front());
        if (!rst && vert_wr_valid && vert_wr_q.size() == 0)
            fail_run("unexpected vertex write record");
        else if (!rst && vert_wr_valid)
            check_vert_wr(vert_wr, vert_wr_q.pop_front());
        if (!rst && tri_wr_valid && tri_wr_q.size() == 0)
            fail_run("unexpected triangle write record");
        else if (!rst && tri_wr_valid)
            check_tri_wr(tri_wr, tri_wr_q.pop_front());
    end

    initial begin
        rst            = 1'b1;
        cs_n           = 1'b1;
        spi_in         = 4'h0;
        reply_expected = 1'b0;
        frame_open     = 1'b0;
        seed           = 32'h8c1a_87a7;
        vert_id        = 0;
        tri_id         = 0;
        vert_base      = 0;
        tri_base       = 0;
        repeat (10) @(negedge sck);
        rst = 1'b0;
        if (spi_oe || vert_hdr_valid || tri_hdr_valid || vert_wr_valid || tri_wr_valid)
            fail_run("outputs are not idle after reset");

        for (int r = 0; r < NUM_VECS; r++) begin
            if (!frame_open)
                start_frame();
            run_command(LINK_VECTORS[r]);
        end
        end_frame();

        if (vert_hdr_q.size() == 0 && tri_hdr_q.size() == 0 &&
            vert_wr_q.size() == 0 && tri_wr_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run("some expected records never appeared");
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
+incdir+dv
logic/raster_link_pkg.sv
logic/frame_counter.sv
logic/link_fsm.sv
logic/nybble_shifter.sv
logic/buffer_allocator.sv
logic/raster_link_top.sv
dv/raster_link_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = raster_link_tb
FILELIST = list.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
